// File: project.f
frame_pkg.sv
line_memory.sv
line_arbiter.sv
frame_csr.sv
frame_reader.sv
frame_release.sv
frame_ring_top.sv
tb_frame_ring.sv

// File: run_sim.sh
#!/bin/sh
# Build the frame ring testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module tb_frame_ring -o sim_frame_ring

./obj_dir/sim_frame_ring > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
   exit 1
fi
exit 0

// File: tb_frame_ring.sv
`timescale 1ns/1ps

module tb_frame_ring
   import frame_pkg::*;
();

   // Handshake waits are counted in cycles, polls in whole AXI reads
   localparam int TIMEOUT    = 200;
   localparam int POLL_LIMIT = 100;

   logic                       clk;
   logic                       resetb;
   logic                       awvalid;
   logic                       awready;
   logic [AXI_ADDR_WIDTH-1:0]  awaddr;
   logic                       wvalid;
   logic                       wready;
   logic [LINE_DATA_WIDTH-1:0] wdata;
   logic                       bvalid;
   logic                       bready;
   logic [1:0]                 bresp;
   logic                       arvalid;
   logic                       arready;
   logic [AXI_ADDR_WIDTH-1:0]  araddr;
   logic                       rvalid;
   logic                       rready;
   logic [LINE_DATA_WIDTH-1:0] rdata;
   logic [1:0]                 rresp;

   // Expected read data, armed by the stimulus for the next read response
   logic                       rd_check;
   logic [LINE_DATA_WIDTH-1:0] exp_rdata;
   // High while the write response is held off by a low bready
   logic                       hold_resp;

   int                         errors = 0;
   int                         cycle = 0;
   logic [31:0]                rng;
   logic [31:0]                exp_hdr [6];
   logic [31:0]                exp_chunk [5];
   logic [31:0]                win_data [6];

   frame_ring_top i_frame_ring_top (
      .clk, .resetb,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
      .bvalid, .bready, .bresp,
      .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // Every completed read is compared with what the stimulus expects
   a_read_value: assert property (@(posedge clk) disable iff (!resetb)
      rvalid && rready && rd_check |-> rdata == exp_rdata)
      else begin
         errors++;
         $display("error rdata got %h expected %h", $sampled(rdata), $sampled(exp_rdata));
      end

   a_bresp_okay: assert property (@(posedge clk) disable iff (!resetb)
      bvalid |-> bresp == RESP_OKAY)
      else begin
         errors++;
         $display("error bresp got %h expected %h", $sampled(bresp), RESP_OKAY);
      end

   a_rresp_okay: assert property (@(posedge clk) disable iff (!resetb)
      rvalid |-> rresp == RESP_OKAY)
      else begin
         errors++;
         $display("error rresp got %h expected %h", $sampled(rresp), RESP_OKAY);
      end

   // While the response is held the old write stays visible and nothing new gets in
   a_resp_held: assert property (@(posedge clk) disable iff (!resetb)
      hold_resp |-> bvalid && !awready)
      else begin
         errors++;
         $display("write response dropped or a second write was accepted under back-pressure");
      end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Line is base pointer, frame, chunk, and each line is one word in the window
   function automatic logic [AXI_ADDR_WIDTH-1:0] window_addr(input int bp, input int frame,
                                                             input int chunk);
      int line;
      line = bp * 32 + frame * 4 + chunk;
      return WINDOW_BASE + AXI_ADDR_WIDTH'(line * 4);
   endfunction

   // Selects both write readies, arready, bvalid or rvalid by index
   function automatic logic handshake_seen(input int sel);
      case (sel)
         0:       return awready && wready;
         1:       return arready;
         2:       return bvalid;
         default: return rvalid;
      endcase
   endfunction

   // Outputs are looked at on the falling edge, away from the rising edge updates
   task automatic wait_for(input int sel, input string what);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!handshake_seen(sel) && n < TIMEOUT);
      if (!handshake_seen(sel)) begin
         errors++;
         $display("timeout waiting for %s", what);
      end
   endtask

   task automatic accept_write(input string what);
      wait_for(0, what);
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
   endtask

   task automatic start_write(input logic [AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wvalid  <= 1'b1;
      accept_write("the write address and data handshake");
   endtask

   task automatic finish_write();
      wait_for(2, "a write response");
      @(posedge clk);
   endtask

   task automatic axi_write(input logic [AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
      start_write(addr, data);
      finish_write();
   endtask

   task automatic axi_read(input logic [AXI_ADDR_WIDTH-1:0] addr, input logic check,
                           input logic [31:0] exp, output logic [31:0] data);
      @(posedge clk);
      araddr    <= addr;
      arvalid   <= 1'b1;
      rd_check  <= check;
      exp_rdata <= exp;
      wait_for(1, "a read address handshake");
      @(posedge clk);
      arvalid <= 1'b0;
      wait_for(3, "a read response");
      data = rdata;
      @(posedge clk);
   endtask

   // Unchecked reads until the value shows up, the caller checks it afterwards
   task automatic poll_until(input logic [AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] target,
                             input string what);
      logic [31:0] v;
      int          n;
      n = 0;
      do begin
         axi_read(addr, 1'b0, '0, v);
         n++;
      end while (v != target && n < POLL_LIMIT);
      if (v != target) begin
         errors++;
         $display("timeout waiting for %s", what);
      end
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s finished, errors so far %0d", num, name, errors);
   endtask

   initial begin
      logic [31:0] v;
      int          start;
      resetb    <= 1'b0;
      awvalid   <= 1'b0;
      awaddr    <= '0;
      wvalid    <= 1'b0;
      wdata     <= '0;
      bready    <= 1'b1;
      arvalid   <= 1'b0;
      araddr    <= '0;
      rready    <= 1'b1;
      rd_check  <= 1'b0;
      exp_rdata <= '0;
      hold_resp <= 1'b0;
      rng = 32'd7;
      repeat (10) @(posedge clk);
      resetb <= 1'b1;

      // The reader polls base 9 frame 0 once enabled, so that header is zeroed first
      axi_read(COUNT_OFFSET, 1'b1, 32'd0, v);
      axi_write(window_addr(9, 0, 0), 32'd0);
      axi_write(BASE_OFFSET, 32'd9);
      axi_write(CTRL_OFFSET, 32'd1);
      axi_read(BASE_OFFSET, 1'b1, 32'd9, v);
      axi_read(CTRL_OFFSET, 1'b1, 32'd1, v);
      axi_write(CTRL_OFFSET, 32'd0);
      axi_read(CTRL_OFFSET, 1'b1, 32'd0, v);
      report_test(1, "register readback");

      for (int i = 0; i < 6; i++) begin
         rng = xorshift32(rng);
         win_data[i] = rng;
         axi_write(window_addr(2, i, i % 4), win_data[i]);
      end
      for (int i = 0; i < 6; i++) begin
         axi_read(window_addr(2, i, i % 4), 1'b1, win_data[i], v);
      end
      report_test(2, "memory window");

      // Frames 0 to 4 carry a set flag, frame 5 stays empty so the reader stops there
      axi_write(BASE_OFFSET, 32'd5);
      for (int f = 0; f < 5; f++) begin
         rng = xorshift32(rng);
         exp_hdr[f] = rng | 32'd1;
         axi_write(window_addr(5, f, 0), exp_hdr[f]);
         rng = xorshift32(rng);
         exp_chunk[f] = rng;
         axi_write(window_addr(5, f, 1), exp_chunk[f]);
      end
      axi_write(window_addr(5, 5, 0), 32'd0);
      axi_write(CTRL_OFFSET, 32'd1);
      poll_until(COUNT_OFFSET, 32'd5, "five frames to be consumed");
      axi_read(COUNT_OFFSET, 1'b1, 32'd5, v);
      axi_read(HEADER_OFFSET, 1'b1, exp_hdr[4], v);
      report_test(3, "frame consumption");

      for (int f = 0; f < 5; f++) begin
         poll_until(window_addr(5, f, 0), 32'd0, "a consumed header to be cleared");
         axi_read(window_addr(5, f, 0), 1'b1, 32'd0, v);
         axi_read(window_addr(5, f, 1), 1'b1, exp_chunk[f], v);
      end
      report_test(4, "release clearing");

      // Frame 6 is zeroed ahead so the reader parks there after frame 5
      axi_write(window_addr(5, 6, 0), 32'd0);
      rng = xorshift32(rng);
      exp_hdr[5] = rng & 32'hFFFF_FFFE;
      axi_write(window_addr(5, 5, 0), exp_hdr[5]);
      start = cycle;
      while (cycle - start < 50) begin
         axi_read(COUNT_OFFSET, 1'b1, 32'd5, v);
      end
      exp_hdr[5] = exp_hdr[5] | 32'd1;
      axi_write(window_addr(5, 5, 0), exp_hdr[5]);
      poll_until(COUNT_OFFSET, 32'd6, "frame 5 to be consumed");
      axi_read(COUNT_OFFSET, 1'b1, 32'd6, v);
      axi_read(HEADER_OFFSET, 1'b1, exp_hdr[5], v);
      poll_until(window_addr(5, 5, 0), 32'd0, "frame 5 header to be cleared");
      axi_read(window_addr(5, 5, 0), 1'b1, 32'd0, v);
      report_test(5, "invalid frame stall");

      // First write finishes into a low bready, the second one waits behind it
      @(posedge clk);
      bready <= 1'b0;
      rng = xorshift32(rng);
      win_data[0] = rng;
      rng = xorshift32(rng);
      win_data[1] = rng;
      start_write(window_addr(3, 0, 0), win_data[0]);
      wait_for(2, "the held write response");
      @(posedge clk);
      hold_resp <= 1'b1;
      awaddr    <= window_addr(3, 1, 0);
      awvalid   <= 1'b1;
      wdata     <= win_data[1];
      wvalid    <= 1'b1;
      repeat (20) @(posedge clk);
      hold_resp <= 1'b0;
      bready    <= 1'b1;
      accept_write("the write queued behind the held response");
      finish_write();
      axi_read(window_addr(3, 0, 0), 1'b1, win_data[0], v);
      axi_read(window_addr(3, 1, 0), 1'b1, win_data[1], v);
      report_test(6, "response back-pressure");

      $display("tests run 6, errors %0d", errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: frame_ring_top.sv
`timescale 1ns/1ps

module frame_ring_top
   import frame_pkg::*;
(
   input  logic                       clk,
   input  logic                       resetb,
   input  logic                       awvalid,
   output logic                       awready,
   input  logic [AXI_ADDR_WIDTH-1:0]  awaddr,
   input  logic                       wvalid,
   output logic                       wready,
   input  logic [LINE_DATA_WIDTH-1:0] wdata,
   output logic                       bvalid,
   input  logic                       bready,
   output logic [1:0]                 bresp,
   input  logic                       arvalid,
   output logic                       arready,
   input  logic [AXI_ADDR_WIDTH-1:0]  araddr,
   output logic                       rvalid,
   input  logic                       rready,
   output logic [LINE_DATA_WIDTH-1:0] rdata,
   output logic [1:0]                 rresp
);

   // Memory requests and responses, indexed by requester
   line_req_t [NUM_REQ-1:0]           reqs;
   line_rsp_t [NUM_REQ-1:0]           rsps;

   logic [LINE_ADDR_WIDTH-1:0]        mem_addr;
   logic                              mem_wr_en;
   logic                              mem_rd_en;
   logic [LINE_DATA_WIDTH-1:0]        mem_wdata;
   logic [LINE_DATA_WIDTH-1:0]        mem_rdata;

   logic                              enable;
   logic [LOG_FRAME_BASE_POINTER-1:0] base_pointer;
   logic                              release_frame;
   logic [COUNT_WIDTH-1:0]            frames_consumed;
   logic [LINE_DATA_WIDTH-1:0]        last_header;

   frame_csr i_frame_csr (
      .clk, .resetb,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
      .bvalid, .bready, .bresp,
      .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
      .mem_req(reqs[REQ_HOST]), .mem_rsp(rsps[REQ_HOST]),
      .enable, .base_pointer, .frames_consumed, .last_header
   );

   frame_reader i_frame_reader (
      .clk, .resetb, .enable, .base_pointer,
      .mem_req(reqs[REQ_READER]), .mem_rsp(rsps[REQ_READER]),
      .release_frame, .frames_consumed, .last_header
   );

   frame_release i_frame_release (
      .clk, .resetb, .base_pointer, .release_frame,
      .mem_req(reqs[REQ_RELEASE]), .mem_rsp(rsps[REQ_RELEASE])
   );

   line_arbiter i_line_arbiter (
      .clk, .resetb, .req(reqs), .rsp(rsps),
      .mem_addr, .mem_wr_en, .mem_rd_en, .mem_wdata, .mem_rdata
   );

   line_memory i_line_memory (
      .clk, .addr(mem_addr), .wr_en(mem_wr_en), .rd_en(mem_rd_en),
      .wdata(mem_wdata), .rdata(mem_rdata)
   );

endmodule

// File: frame_release.sv
`timescale 1ns/1ps

module frame_release
   import frame_pkg::*;
(
   input  logic                              clk,
   input  logic                              resetb,
   input  logic [LOG_FRAME_BASE_POINTER-1:0] base_pointer,
   input  logic                              release_frame,
   output line_req_t                         mem_req,
   input  line_rsp_t                         mem_rsp
);

   // Frames consumed but whose header is still to be zeroed
   logic [COUNT_WIDTH-1:0]      pending;
   // Next frame to clear, trails the reader in ring order
   logic [LOG_FRAME_NUMBER-1:0] clear_frame;

   // Writing zero to the header drops the valid flag and hands the frame back
   assign mem_req.request = (pending != '0);
   assign mem_req.op      = WR_LINE;
   assign mem_req.addr    = {base_pointer, clear_frame, {LOG_FRAME_CHUNKS{1'b0}}};
   assign mem_req.wdata   = '0;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         pending     <= '0;
         clear_frame <= '0;
      end else begin
         // A release and a grant in the same cycle cancel out
         pending     <= pending + COUNT_WIDTH'(release_frame) - COUNT_WIDTH'(mem_rsp.grant);
         clear_frame <= clear_frame + LOG_FRAME_NUMBER'(mem_rsp.grant);
      end
   end

   // The arbiter must never grant a clear while nothing is pending
   a_no_underflow: assert property (@(posedge clk) disable iff (!resetb)
      pending == '0 |-> !mem_rsp.grant);

endmodule

// File: frame_reader.sv
`timescale 1ns/1ps

module frame_reader
   import frame_pkg::*;
(
   input  logic                              clk,
   input  logic                              resetb,
   input  logic                              enable,
   input  logic [LOG_FRAME_BASE_POINTER-1:0] base_pointer,
   output line_req_t                         mem_req,
   input  line_rsp_t                         mem_rsp,
   output logic                              release_frame,
   output logic [COUNT_WIDTH-1:0]            frames_consumed,
   output logic [LINE_DATA_WIDTH-1:0]        last_header
);

   reader_state_e               state;
   logic [LOG_FRAME_NUMBER-1:0] frame_number;

   // The header sits in chunk 0 of the frame being polled
   assign mem_req.request = (state == POLL);
   assign mem_req.op      = RD_LINE;
   assign mem_req.addr    = {base_pointer, frame_number, {LOG_FRAME_CHUNKS{1'b0}}};
   assign mem_req.wdata   = '0;

   // Release goes out in the same cycle the flagged header arrives
   assign release_frame = (state == WAIT_DATA) && mem_rsp.rd_valid && mem_rsp.rdata[0];

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state           <= IDLE;
         frame_number    <= '0;
         frames_consumed <= '0;
         last_header     <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (enable) begin
                  state <= POLL;
               end
            end
            // The request stays up until the arbiter takes it
            POLL: begin
               if (mem_rsp.grant) begin
                  state <= WAIT_DATA;
               end
            end
            WAIT_DATA: begin
               if (mem_rsp.rd_valid) begin
                  state <= enable ? POLL : IDLE;
                  // A clear flag means the host has not filled it yet, so poll it again
                  if (mem_rsp.rdata[0]) begin
                     last_header     <= mem_rsp.rdata;
                     frames_consumed <= frames_consumed + 1'b1;
                     frame_number    <= frame_number + 1'b1;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Header data comes back exactly one cycle after the grant
   a_header_returns: assert property (@(posedge clk) disable iff (!resetb)
      state == WAIT_DATA |-> mem_rsp.rd_valid);

endmodule

// File: frame_csr.sv
`timescale 1ns/1ps

module frame_csr
   import frame_pkg::*;
(
   input  logic                              clk,
   input  logic                              resetb,
   input  logic                              awvalid,
   output logic                              awready,
   input  logic [AXI_ADDR_WIDTH-1:0]         awaddr,
   input  logic                              wvalid,
   output logic                              wready,
   input  logic [LINE_DATA_WIDTH-1:0]        wdata,
   output logic                              bvalid,
   input  logic                              bready,
   output logic [1:0]                        bresp,
   input  logic                              arvalid,
   output logic                              arready,
   input  logic [AXI_ADDR_WIDTH-1:0]         araddr,
   output logic                              rvalid,
   input  logic                              rready,
   output logic [LINE_DATA_WIDTH-1:0]        rdata,
   output logic [1:0]                        rresp,
   output line_req_t                         mem_req,
   input  line_rsp_t                         mem_rsp,
   output logic                              enable,
   output logic [LOG_FRAME_BASE_POINTER-1:0] base_pointer,
   input  logic [COUNT_WIDTH-1:0]            frames_consumed,
   input  logic [LINE_DATA_WIDTH-1:0]        last_header
);

   logic                       busy;
   logic                       rd_wait;
   logic                       aw_win;
   logic                       ar_win;
   logic [AXI_ADDR_WIDTH-1:0]  aw_off;
   logic [AXI_ADDR_WIDTH-1:0]  ar_off;
   logic [LINE_DATA_WIDTH-1:0] reg_rdata;

   // Window offsets, bits 10 to 2 of the offset pick the memory line
   assign aw_win = awaddr >= WINDOW_BASE;
   assign ar_win = araddr >= WINDOW_BASE;
   assign aw_off = awaddr - WINDOW_BASE;
   assign ar_off = araddr - WINDOW_BASE;

   // Only one transaction is in flight, from the ready pulse to the response
   assign busy = awready || arready || bvalid || rvalid || rd_wait || mem_req.request;

   assign bresp = RESP_OKAY;
   assign rresp = RESP_OKAY;

   always_comb begin
      case (araddr)
         CTRL_OFFSET:   reg_rdata = LINE_DATA_WIDTH'(enable);
         BASE_OFFSET:   reg_rdata = LINE_DATA_WIDTH'(base_pointer);
         COUNT_OFFSET:  reg_rdata = LINE_DATA_WIDTH'(frames_consumed);
         HEADER_OFFSET: reg_rdata = last_header;
         default:       reg_rdata = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         awready         <= 1'b0;
         wready          <= 1'b0;
         arready         <= 1'b0;
         bvalid          <= 1'b0;
         rvalid          <= 1'b0;
         rd_wait         <= 1'b0;
         mem_req.request <= 1'b0;
         enable          <= 1'b0;
         base_pointer    <= '0;
      end else begin
         // Ready is a one cycle pulse, writes win over reads when both wait
         awready <= awvalid && wvalid && !busy;
         wready  <= awvalid && wvalid && !busy;
         arready <= arvalid && !(awvalid && wvalid) && !busy;

         if (awready && awvalid && wready && wvalid) begin
            if (aw_win) begin
               mem_req.request <= 1'b1;
               mem_req.op      <= WR_LINE;
               mem_req.addr    <= aw_off[LINE_ADDR_WIDTH+1:2];
               mem_req.wdata   <= wdata;
            end else begin
               bvalid <= 1'b1;
               if (awaddr == CTRL_OFFSET) begin
                  enable <= wdata[0];
               end
               if (awaddr == BASE_OFFSET) begin
                  base_pointer <= wdata[LOG_FRAME_BASE_POINTER-1:0];
               end
            end
         end

         if (arready && arvalid) begin
            if (ar_win) begin
               mem_req.request <= 1'b1;
               mem_req.op      <= RD_LINE;
               mem_req.addr    <= ar_off[LINE_ADDR_WIDTH+1:2];
               mem_req.wdata   <= '0;
            end else begin
               rvalid <= 1'b1;
               rdata  <= reg_rdata;
            end
         end

         // A write is done at its grant, a read waits for the data
         if (mem_req.request && mem_rsp.grant) begin
            mem_req.request <= 1'b0;
            if (mem_req.op == WR_LINE) begin
               bvalid <= 1'b1;
            end else begin
               rd_wait <= 1'b1;
            end
         end

         if (rd_wait && mem_rsp.rd_valid) begin
            rd_wait <= 1'b0;
            rvalid  <= 1'b1;
            rdata   <= mem_rsp.rdata;
         end

         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   a_bvalid_held: assert property (@(posedge clk) disable iff (!resetb)
      bvalid && !bready |=> bvalid);

endmodule

// File: line_arbiter.sv
`timescale 1ns/1ps

module line_arbiter
   import frame_pkg::*;
(
   input  logic                       clk,
   input  logic                       resetb,
   input  line_req_t [NUM_REQ-1:0]    req,
   output line_rsp_t [NUM_REQ-1:0]    rsp,
   output logic [LINE_ADDR_WIDTH-1:0] mem_addr,
   output logic                       mem_wr_en,
   output logic                       mem_rd_en,
   output logic [LINE_DATA_WIDTH-1:0] mem_wdata,
   input  logic [LINE_DATA_WIDTH-1:0] mem_rdata
);

   logic [REQ_SEL_WIDTH-1:0] last;
   logic [REQ_SEL_WIDTH-1:0] sel;
   logic [NUM_REQ-1:0]       gnt;
   logic [NUM_REQ-1:0]       rd_pend;

   // Search starts just after the previous winner and takes the first request
   always_comb begin
      int idx;
      gnt = '0;
      sel = '0;
      for (int k = 1; k <= NUM_REQ; k++) begin
         idx = int'(last) + k;
         if (idx >= NUM_REQ) begin
            idx = idx - NUM_REQ;
         end
         if (req[idx].request && (gnt == '0)) begin
            gnt[idx] = 1'b1;
            sel      = REQ_SEL_WIDTH'(idx);
         end
      end
   end

   // The winner's fields go straight to the single memory port
   assign mem_addr  = req[sel].addr;
   assign mem_wdata = req[sel].wdata;
   assign mem_wr_en = (gnt != '0) && (req[sel].op == WR_LINE);
   assign mem_rd_en = (gnt != '0) && (req[sel].op == RD_LINE);

   always_ff @(posedge clk) begin
      if (!resetb) begin
         // Host gets first pick after reset
         last    <= REQ_SEL_WIDTH'(NUM_REQ - 1);
         rd_pend <= '0;
      end else begin
         if (gnt != '0) begin
            last <= sel;
         end
         // Remember who owns the data coming out of memory next cycle
         for (int i = 0; i < NUM_REQ; i++) begin
            rd_pend[i] <= gnt[i] && (req[i].op == RD_LINE);
         end
      end
   end

   // Read data is broadcast, only the owner sees rd_valid
   always_comb begin
      for (int i = 0; i < NUM_REQ; i++) begin
         rsp[i].grant    = gnt[i];
         rsp[i].rd_valid = rd_pend[i];
         rsp[i].rdata    = mem_rdata;
      end
   end

   a_grant_onehot: assert property (@(posedge clk) disable iff (!resetb) $onehot0(gnt));

   for (genvar g = 0; g < NUM_REQ; g++) begin : g_grant_chk
      a_grant_has_req: assert property (@(posedge clk) disable iff (!resetb)
         gnt[g] |-> req[g].request);
   end

endmodule

// File: line_memory.sv
`timescale 1ns/1ps

module line_memory
   import frame_pkg::*;
(
   input  logic                       clk,
   input  logic [LINE_ADDR_WIDTH-1:0] addr,
   input  logic                       wr_en,
   input  logic                       rd_en,
   input  logic [LINE_DATA_WIDTH-1:0] wdata,
   output logic [LINE_DATA_WIDTH-1:0] rdata
);

   // One word per line, the whole address space is backed
   logic [LINE_DATA_WIDTH-1:0] mem [LINE_COUNT];

   // Writes land on the edge of the grant
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[addr] <= wdata;
      end
   end

   // Read data is registered, so it shows one cycle after rd_en
   // and then holds until the next read
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rdata <= mem[addr];
      end
   end

endmodule

// File: frame_pkg.sv
package frame_pkg;

   // Line address layout is base pointer, then frame number, then chunk
   localparam int LOG_FRAME_BASE_POINTER = 4;
   localparam int LOG_FRAME_NUMBER       = 3;
   localparam int LOG_FRAME_CHUNKS       = 2;
   localparam int LINE_ADDR_WIDTH        = LOG_FRAME_BASE_POINTER + LOG_FRAME_NUMBER +
                                           LOG_FRAME_CHUNKS;
   localparam int LINE_COUNT             = 1 << LINE_ADDR_WIDTH;
   localparam int LINE_DATA_WIDTH        = 32;

   // Width of the consumed frame counter seen by the host
   localparam int COUNT_WIDTH = 16;

   // Host side AXI4-Lite address width and the OKAY response code
   localparam int             AXI_ADDR_WIDTH = 12;
   localparam logic [1:0]     RESP_OKAY      = 2'b00;

   // Register map, all offsets are byte addresses
   localparam logic [AXI_ADDR_WIDTH-1:0] CTRL_OFFSET   = 12'h000;
   localparam logic [AXI_ADDR_WIDTH-1:0] BASE_OFFSET   = 12'h004;
   localparam logic [AXI_ADDR_WIDTH-1:0] COUNT_OFFSET  = 12'h008;
   localparam logic [AXI_ADDR_WIDTH-1:0] HEADER_OFFSET = 12'h00C;
   // Everything from here up maps onto memory lines, one line per word
   localparam logic [AXI_ADDR_WIDTH-1:0] WINDOW_BASE   = 12'h400;

   // Requester indices at the line memory arbiter
   localparam int NUM_REQ       = 3;
   localparam int REQ_SEL_WIDTH = 2;
   localparam int REQ_HOST      = 0;
   localparam int REQ_READER    = 1;
   localparam int REQ_RELEASE   = 2;

   typedef enum logic {
      RD_LINE = 1'b0,
      WR_LINE = 1'b1
   } line_op_e;

   // A requester holds this steady until it sees grant
   typedef struct packed {
      logic                       request;
      line_op_e                   op;
      logic [LINE_ADDR_WIDTH-1:0] addr;
      logic [LINE_DATA_WIDTH-1:0] wdata;
   } line_req_t;

   // Grant is same cycle, rd_valid follows a read grant by one cycle
   typedef struct packed {
      logic                       grant;
      logic                       rd_valid;
      logic [LINE_DATA_WIDTH-1:0] rdata;
   } line_rsp_t;

   typedef enum logic [1:0] {
      IDLE      = 2'd0,
      POLL      = 2'd1,
      WAIT_DATA = 2'd2
   } reader_state_e;

endpackage
